// ==== build.f ====
+incdir+include
design/circle_pkg.sv
design/screen_fill.sv
design/datapath.sv
design/circle_fsm.sv
design/circle.sv
testbench/circle_checker.sv
testbench/circle_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= circle_tb
LOG       ?= sim.log
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAIL" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/circle_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "circle_macros.svh"

module circle_tb;

  localparam int FILL_PLOTS = `SCREEN_W * `SCREEN_H;

  logic                    clk = 1'b0;
  logic                    reset = 1'b1;
  logic                    start = 1'b0;
  circle_pkg::circle_req_t req = '0;
  logic                    done;
  circle_pkg::pixel_t      vga;
  logic                    vga_plot;

  circle_pkg::pixel_t plots[$];     // Every plot in order since the last request
  circle_pkg::pixel_t expect_q[$];
  circle_pkg::pixel_t frame [`SCREEN_W][`SCREEN_H];
  circle_pkg::pixel_t model_frame [`SCREEN_W][`SCREEN_H];
  int                 errors = 0;
  int                 timeouts = 0;
  int                 seed = 32'h0de91804;

  circle dut (
    .clk(clk), .reset(reset), .start(start), .req(req),
    .done(done), .vga(vga), .vga_plot(vga_plot)
  );

  bind circle circle_checker port_checks (
    .clk(clk), .reset(reset), .start(start), .done(done), .vga(vga), .vga_plot(vga_plot)
  );

  always #20 clk = ~clk;

  // Outputs settle after the rising edge, so they are taken mid-cycle
  always @(negedge clk) begin
    if (vga_plot === 1'b1) begin
      plots.push_back(vga);
      if (vga.x < `SCREEN_W && vga.y < `SCREEN_H) frame[vga.x][vga.y] = vga;
    end
  end

  task automatic compare_pixel(input string name, input circle_pkg::pixel_t exp,
                               input circle_pkg::pixel_t act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected x=%0d y=%0d c=%0d, actual x=%0d y=%0d c=%0d",
               name, exp.x, exp.y, exp.colour, act.x, act.y, act.colour);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // Midpoint rule with clipping, in plain integers
  function automatic void midpoint_model(input circle_pkg::circle_req_t r);
    int ox;
    int oy;
    int crit;
    int cx;
    int cy;
    int px [8];
    int py [8];
    circle_pkg::pixel_t p;
    expect_q.delete();
    cx = r.centre_x;
    cy = r.centre_y;
    ox = r.radius;
    oy = 0;
    crit = 1 - ox;
    while (oy <= ox) begin
      px = '{cx + ox, cx + oy, cx - ox, cx - oy, cx - ox, cx - oy, cx + ox, cx + oy};
      py = '{cy + oy, cy + ox, cy + oy, cy + ox, cy - oy, cy - ox, cy - oy, cy - ox};
      for (int k = 0; k < 8; k++) begin
        if (px[k] >= 0 && px[k] < `SCREEN_W && py[k] >= 0 && py[k] < `SCREEN_H) begin
          p.x = px[k][`COORD_X_BITS-1:0];
          p.y = py[k][`COORD_Y_BITS-1:0];
          p.colour = r.colour;
          expect_q.push_back(p);
        end
      end
      oy = oy + 1;
      if (crit <= 0) begin
        crit = crit + 2 * oy + 1;
      end else begin
        ox = ox - 1;
        crit = crit + 2 * (oy - ox) + 1;
      end
    end
  endfunction

  task automatic wait_done(input string name);
    int cycles;
    cycles = 0;
    while (done !== 1'b1 && cycles < 40000) begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      timeouts++;
      $display("timeout in %s: done did not rise within 40000 cycles", name);
    end
  endtask

  task automatic check_fill(input string name);
    circle_pkg::pixel_t exp;
    if (plots.size() < FILL_PLOTS) begin
      compare_count({name, " fill count"}, FILL_PLOTS, plots.size());
      return;
    end
    exp.colour = '0;
    for (int i = 0; i < FILL_PLOTS; i++) begin
      exp.x = (i % `SCREEN_W);  // Raster order, x fastest
      exp.y = (i / `SCREEN_W);
      if (plots[i] !== exp) begin
        compare_pixel({name, " fill"}, exp, plots[i]);
        return;
      end
    end
  endtask

  task automatic check_circle(input string name, input circle_pkg::circle_req_t r);
    int n;
    circle_pkg::pixel_t p;
    midpoint_model(r);
    n = plots.size() - FILL_PLOTS;
    compare_count({name, " circle plot count"}, expect_q.size(), n);
    for (int i = 0; i < expect_q.size() && i < n; i++) begin
      if (plots[FILL_PLOTS + i] !== expect_q[i]) begin
        compare_pixel({name, " circle plot"}, expect_q[i], plots[FILL_PLOTS + i]);
        break;
      end
    end
    p.colour = '0;
    for (int x = 0; x < `SCREEN_W; x++) begin
      for (int y = 0; y < `SCREEN_H; y++) begin
        p.x = x[`COORD_X_BITS-1:0];
        p.y = y[`COORD_Y_BITS-1:0];
        model_frame[x][y] = p;
      end
    end
    foreach (expect_q[i]) model_frame[expect_q[i].x][expect_q[i].y] = expect_q[i];
    for (int x = 0; x < `SCREEN_W; x++) begin
      for (int y = 0; y < `SCREEN_H; y++) begin
        if (frame[x][y] !== model_frame[x][y]) begin
          compare_pixel({name, " frame"}, model_frame[x][y], frame[x][y]);
          return;
        end
      end
    end
  endtask

  task automatic draw(input string name, input circle_pkg::circle_req_t r);
    @(negedge clk);
    plots.delete();
    req = r;
    start = 1'b1;
    wait_done(name);
    check_fill(name);
    check_circle(name, r);
  endtask

  task automatic release_start(input string name);
    start = 1'b0;
    @(negedge clk);
    compare_bit({name, " done after start low"}, 1'b0, done);
  endtask

  task automatic test_shapes();
    draw("centred r30", '{centre_x: 8'd80, centre_y: 7'd60, radius: 8'd30, colour: 3'd5});
    release_start("centred r30");
    draw("corner r20", '{centre_x: 8'd2, centre_y: 7'd3, radius: 8'd20, colour: 3'd2});
    release_start("corner r20");
    draw("radius 0", '{centre_x: 8'd40, centre_y: 7'd70, radius: 8'd0, colour: 3'd7});
    compare_count("radius 0 centre plots", 8, plots.size() - FILL_PLOTS);
    release_start("radius 0");
  endtask

  task automatic test_done_hold();
    circle_pkg::circle_req_t r;
    logic [31:0] rnd;
    draw("done hold", '{centre_x: 8'd100, centre_y: 7'd50, radius: 8'd12, colour: 3'd3});
    repeat (5) begin
      @(negedge clk);
      compare_bit("done hold while start high", 1'b1, done);
    end
    release_start("done hold");
    rnd = $random(seed);
    r.centre_x = rnd[7:0] % 8'd160;
    r.centre_y = rnd[14:8] % 7'd120;
    r.radius = rnd[23:16] % 8'd90;
    r.colour = rnd[26:24];
    draw("random second request", r);
    release_start("random second request");
  endtask

  task automatic test_reset_mid_fill();
    circle_pkg::circle_req_t r;
    r = '{centre_x: 8'd60, centre_y: 7'd40, radius: 8'd25, colour: 3'd6};
    @(negedge clk);
    req = r;
    start = 1'b1;
    repeat (500) @(negedge clk);
    compare_bit("reset mid fill plotting before reset", 1'b1, vga_plot);
    reset = 1'b1;
    @(negedge clk);
    compare_bit("reset mid fill vga_plot", 1'b0, vga_plot);
    compare_bit("reset mid fill done", 1'b0, done);
    reset = 1'b0;
    start = 1'b0;
    draw("after reset", r);
    release_start("after reset");
  endtask

  initial begin
    repeat (2) @(negedge clk);
    reset = 1'b0;
    test_shapes();
    test_done_hold();
    test_reset_mid_fill();
    $display("closing counts: errors=%0d timeouts=%0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/circle_checker.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "circle_macros.svh"

module circle_checker (
  input logic               clk,
  input logic               reset,
  input logic               start,
  input logic               done,
  input circle_pkg::pixel_t vga,
  input logic               vga_plot
);

  reset_quiet: assert property (@(posedge clk) reset |=> !vga_plot && !done)
    else $error("vga_plot or done active in the cycle after reset");

  // The adapter only accepts coordinates inside the visible screen
  plot_on_screen: assert property (@(posedge clk) disable iff (reset)
    vga_plot |-> (vga.x < `SCREEN_W) && (vga.y < `SCREEN_H))
    else $error("pixel written outside the screen");

  done_needs_start: assert property (@(posedge clk) disable iff (reset)
    $rose(done) |-> $past(start))
    else $error("done rose while start was low");

  no_plot_when_done: assert property (@(posedge clk) disable iff (reset) done |-> !vga_plot)
    else $error("pixel written while done is high");

endmodule

`default_nettype wire

// ==== design/circle.sv ====
`timescale 1ns/1ns
`default_nettype none

module circle (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  circle_pkg::circle_req_t req,
  output logic                    done,
  output circle_pkg::pixel_t      vga,
  output logic                    vga_plot
);

  circle_pkg::dp_ctrl_t   ctrl;
  circle_pkg::dp_status_t status;
  circle_pkg::pixel_t     fill_pixel;
  circle_pkg::pixel_t     dp_pixel;
  logic                   fill_plot;
  logic                   dp_plot;
  logic                   fill_start;
  logic                   fill_done;
  logic                   fill_active;

  circle_fsm fsm (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .status      (status),
    .fill_done   (fill_done),
    .fill_start  (fill_start),
    .fill_active (fill_active),
    .ctrl        (ctrl),
    .done        (done)
  );

  datapath dp (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .ctrl   (ctrl),
    .status (status),
    .pixel  (dp_pixel),
    .plot   (dp_plot)
  );

  screen_fill fill (
    .clk        (clk),
    .reset      (reset),
    .fill_start (fill_start),
    .fill_done  (fill_done),
    .pixel      (fill_pixel),
    .plot       (fill_plot)
  );

  // The two pixel streams never overlap in time
  assign vga      = fill_active ? fill_pixel : dp_pixel;
  assign vga_plot = fill_active ? fill_plot : dp_plot;

endmodule

`default_nettype wire

// ==== design/circle_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module circle_fsm (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  circle_pkg::dp_status_t status,
  input  logic                   fill_done,
  output logic                   fill_start,
  output logic                   fill_active,
  output circle_pkg::dp_ctrl_t   ctrl,
  output logic                   done
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FILL,
    S_LOAD,
    S_PLOT,
    S_STEP,
    S_DONE
  } state_t;

  state_t               state;
  circle_pkg::octant_t  octant;
  logic                 in_loop;

  // Loop runs while offset_y <= offset_x
  assign in_loop = status.offset_y <= status.offset_x;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= S_IDLE;
      octant     <= circle_pkg::OCT_0;
      fill_start <= 1'b0;
    end else begin
      fill_start <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            fill_start <= 1'b1;
            state      <= S_FILL;
          end
        end
        S_FILL: begin
          if (fill_done) state <= S_LOAD;
        end
        S_LOAD: begin
          octant <= circle_pkg::OCT_0;
          state  <= S_PLOT;
        end
        S_PLOT: begin
          if (octant == circle_pkg::OCT_0 && !in_loop) begin
            // A withdrawn start skips done altogether
            state <= start ? S_DONE : S_IDLE;
          end else if (octant == circle_pkg::OCT_7) begin
            state <= S_STEP;
          end else begin
            octant <= circle_pkg::octant_t'(octant + 3'd1);
          end
        end
        S_STEP: begin
          octant <= circle_pkg::OCT_0;
          state  <= S_PLOT;
        end
        S_DONE: begin
          if (!start) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_comb begin
    ctrl.load    = (state == S_LOAD);
    ctrl.step    = (state == S_STEP);
    ctrl.plot_en = (state == S_PLOT) && in_loop;  // Low in the final test cycle
    ctrl.octant  = octant;
  end

  assign fill_active = (state == S_FILL);
  assign done        = (state == S_DONE);

endmodule

`default_nettype wire

// ==== design/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "circle_macros.svh"

module datapath (
  input  logic                    clk,
  input  logic                    reset,
  input  circle_pkg::circle_req_t req,
  input  circle_pkg::dp_ctrl_t    ctrl,
  output circle_pkg::dp_status_t  status,
  output circle_pkg::pixel_t      pixel,
  output logic                    plot
);

  logic signed [8:0]  offset_x;
  logic signed [7:0]  offset_y;
  logic signed [10:0] crit;

  logic signed [10:0] x_wide;
  logic signed [10:0] y_wide;
  logic signed [10:0] x_next;
  logic signed [10:0] y_next;
  logic signed [10:0] centre_x;
  logic signed [10:0] centre_y;
  logic signed [10:0] du;
  logic signed [10:0] dv;
  logic signed [10:0] point_x;
  logic signed [10:0] point_y;
  logic               on_screen;

  assign x_wide   = offset_x;
  assign y_wide   = offset_y;
  assign x_next   = x_wide - 11'sd1;
  assign y_next   = y_wide + 11'sd1;
  assign centre_x = {3'b000, req.centre_x};
  assign centre_y = {4'b0000, req.centre_y};

  always_ff @(posedge clk) begin
    if (reset) begin
      offset_x <= '0;
      offset_y <= '0;
      crit     <= '0;
    end else if (ctrl.load) begin
      offset_x <= {1'b0, req.radius};
      offset_y <= '0;
      crit     <= 11'sd1 - signed'({3'b000, req.radius});
    end else if (ctrl.step) begin
      offset_y <= y_next[7:0];
      if (crit <= 0) begin
        crit <= crit + (y_next <<< 1) + 11'sd1;
      end else begin
        // Both terms use the already updated offsets
        offset_x <= x_next[8:0];
        crit     <= crit + ((y_next - x_next) <<< 1) + 11'sd1;
      end
    end
  end

  assign status.offset_x = offset_x;
  assign status.offset_y = offset_y;

  // Octant point from the encoding of octant_t
  assign du      = ctrl.octant[0] ? y_wide : x_wide;
  assign dv      = ctrl.octant[0] ? x_wide : y_wide;
  assign point_x = (ctrl.octant[2] ^ ctrl.octant[1]) ? centre_x - du : centre_x + du;
  assign point_y = ctrl.octant[2] ? centre_y - dv : centre_y + dv;

  assign on_screen = (point_x >= 0) && (point_x < `SCREEN_W) &&
                     (point_y >= 0) && (point_y < `SCREEN_H);

  always_ff @(posedge clk) begin
    if (reset) begin
      plot <= 1'b0;
    end else begin
      plot <= ctrl.plot_en && on_screen;  // Clipped points are simply not written
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.plot_en) begin
      pixel.x      <= point_x[`COORD_X_BITS-1:0];
      pixel.y      <= point_y[`COORD_Y_BITS-1:0];
      pixel.colour <= req.colour;
    end
  end

endmodule

`default_nettype wire

// ==== design/screen_fill.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "circle_macros.svh"

module screen_fill (
  input  logic               clk,
  input  logic               reset,
  input  logic               fill_start,
  output logic               fill_done,
  output circle_pkg::pixel_t pixel,
  output logic               plot
);

  logic                     active;
  logic [`COORD_X_BITS-1:0] x;
  logic [`COORD_Y_BITS-1:0] y;

  always_ff @(posedge clk) begin
    if (reset) begin
      active    <= 1'b0;
      fill_done <= 1'b0;
      x         <= '0;
      y         <= '0;
    end else begin
      fill_done <= 1'b0;
      if (fill_start) begin
        active <= 1'b1;
        x      <= '0;
        y      <= '0;
      end else if (active) begin
        if (x == `SCREEN_W - 1) begin
          x <= '0;
          if (y == `SCREEN_H - 1) begin  // Last pixel of the frame
            active    <= 1'b0;
            fill_done <= 1'b1;
            y         <= '0;
          end else begin
            y <= y + 1'b1;
          end
        end else begin
          x <= x + 1'b1;
        end
      end
    end
  end

  assign pixel.x      = x;
  assign pixel.y      = y;
  assign pixel.colour = '0;  // Black
  assign plot         = active;

endmodule

`default_nettype wire

// ==== design/circle_pkg.sv ====
`default_nettype none
`include "circle_macros.svh"

package circle_pkg;

  // One pixel write to the adapter
  typedef struct packed {
    logic [`COORD_X_BITS-1:0] x;
    logic [`COORD_Y_BITS-1:0] y;
    logic [`COLOUR_BITS-1:0]  colour;
  } pixel_t;

  typedef struct packed {
    logic [`COORD_X_BITS-1:0] centre_x;
    logic [`COORD_Y_BITS-1:0] centre_y;
    logic [7:0]               radius;
    logic [`COLOUR_BITS-1:0]  colour;
  } circle_req_t;

  // Bit 0 swaps the offsets, bit 2 negates the y term, bit 2 xor bit 1 negates the x term
  typedef enum logic [2:0] {
    OCT_0, OCT_1, OCT_2, OCT_3, OCT_4, OCT_5, OCT_6, OCT_7
  } octant_t;

  typedef struct packed {
    logic    load;     // Start a new circle from the request
    logic    step;     // One midpoint iteration
    logic    plot_en;
    octant_t octant;
  } dp_ctrl_t;

  typedef struct packed {
    logic signed [8:0] offset_x;
    logic signed [7:0] offset_y;
  } dp_status_t;

endpackage

`default_nettype wire

// ==== include/circle_macros.svh ====
`ifndef CIRCLE_MACROS_SVH
`define CIRCLE_MACROS_SVH

// Visible screen size in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// Field widths of the VGA adapter port
`define COORD_X_BITS 8
`define COORD_Y_BITS 7
`define COLOUR_BITS 3

`endif
